// ==== flist.f ====
+incdir+.
hm_seq_pkg.sv
hm_csr_pkg.sv
hm_csr_regs.sv
hm_sequencer.sv
hm_buffer.sv
hm_top.sv
tb_hm_top.sv

// ==== hm_buffer.sv ====
`timescale 1ns/1ps
`include "hm_settings.svh"

module hm_buffer (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  logic [31:0]           wb_adr_i,
  input  hm_csr_pkg::hm_word_t  wb_dat_i,
  input  logic [3:0]            wb_sel_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_we_i,
  input  hm_csr_pkg::hm_dword_t hm_addr_i,
  output hm_csr_pkg::hm_word_t  wb_dat_o,
  output logic                  wb_ack_o,
  output hm_csr_pkg::hm_dword_t hm_data_o
);
  import hm_csr_pkg::*;

  logic         wb_en;
  hm_buf_addr_t buf_idx;
  hm_word_t     dat_rev;
  logic [3:0]   sel_rev;
  hm_word_t     rd_lo;
  hm_word_t     rd_hi;
  hm_word_t     rd_half;

  assign wb_en = wb_cyc_i & wb_stb_i;

  // Wishbone owns the index while a cycle is active
  assign buf_idx = wb_en ? wb_adr_i[`HM_BUF_ADDR_BITS+2:3]
                         : hm_addr_i[`HM_BUF_ADDR_BITS+2:3];

  // Buffer stores words with byte lanes reversed
  assign dat_rev = {wb_dat_i[7:0], wb_dat_i[15:8], wb_dat_i[23:16], wb_dat_i[31:24]};
  assign sel_rev = {wb_sel_i[0], wb_sel_i[1], wb_sel_i[2], wb_sel_i[3]};

  // Half 0 holds the low word, half 1 the high word
  for (genvar g = 0; g < 2; g++) begin : gen_half
    hm_word_t mem [0:(1 << `HM_BUF_ADDR_BITS)-1];
    hm_word_t rd_q;
    logic     wr_en;

    assign wr_en = wb_en & wb_we_i & (wb_adr_i[2] == 1'(g));

    always_ff @(posedge sys_clk) begin
      if (wr_en) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_rev[b]) begin
            mem[buf_idx][b*8 +: 8] <= dat_rev[b*8 +: 8];
          end
        end
      end
      rd_q <= mem[buf_idx];
    end
  end

  assign rd_lo = gen_half[0].rd_q;
  assign rd_hi = gen_half[1].rd_q;

  // Half select follows the address held through the ack cycle
  assign rd_half  = wb_adr_i[2] ? rd_hi : rd_lo;
  assign wb_dat_o = {rd_half[7:0], rd_half[15:8], rd_half[23:16], rd_half[31:24]};

  // Host sees the stored words unchanged
  assign hm_data_o = {rd_hi, rd_lo};

  // One ack per access, never two cycles in a row
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_en & ~wb_ack_o;
    end
  end

endmodule

// ==== hm_csr_pkg.sv ====
`include "hm_settings.svh"

package hm_csr_pkg;

  // Register offsets within the CSR bank
  typedef enum logic [`HM_CSR_OFS_BITS-1:0] {
    HM_CSR_STAT    = 0,
    HM_CSR_CTRL    = 1,
    HM_CSR_ADDR_LO = 2,
    HM_CSR_ADDR_HI = 3,
    HM_CSR_STATE   = 4
  } hm_csr_reg_e;

  // CSR and Wishbone data word
  typedef logic [`HM_WORD_BITS-1:0] hm_word_t;

  // Buffer word and host address
  typedef logic [`HM_DWORD_BITS-1:0] hm_dword_t;

  // Buffer entry index
  typedef logic [`HM_BUF_ADDR_BITS-1:0] hm_buf_addr_t;

endpackage

// ==== hm_csr_regs.sv ====
`timescale 1ns/1ps
`include "hm_settings.svh"

module hm_csr_regs (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  logic [13:0]           csr_a_i,
  input  logic                  csr_we_i,
  input  hm_csr_pkg::hm_word_t  csr_di_i,
  output hm_csr_pkg::hm_word_t  csr_do_o,
  input  hm_seq_pkg::hm_state_e seq_state_i,
  input  logic                  seq_end_i,
  input  logic                  seq_tx_timeout_i,
  input  logic                  seq_rx_timeout_i,
  output logic                  seq_start_o,
  output hm_csr_pkg::hm_dword_t tx_addr_o,
  output logic                  irq_o
);
  import hm_csr_pkg::*;
  import hm_seq_pkg::*;

  logic        bank_sel;
  hm_csr_reg_e reg_ofs;
  logic        seq_idle;
  hm_word_t    rd_data;

  logic        irq_en_q;
  logic        start_q;
  logic        ev_end_q;
  logic        ev_tx_to_q;
  logic        ev_rx_to_q;
  hm_dword_t   addr_q;

  assign bank_sel = (csr_a_i[13:10] == `HM_CSR_BANK);
  assign reg_ofs  = hm_csr_reg_e'(csr_a_i[`HM_CSR_OFS_BITS-1:0]);
  assign seq_idle = (seq_state_i == HM_IDLE);

  // Read data, zero outside the bank or on unknown offsets
  always_comb begin
    rd_data = '0;
    if (bank_sel) begin
      case (reg_ofs)
        HM_CSR_STAT: begin
          rd_data[2:0] = {ev_rx_to_q, ev_tx_to_q, ev_end_q};
        end
        HM_CSR_CTRL: begin
          rd_data[1:0] = {start_q, irq_en_q};
        end
        HM_CSR_ADDR_LO: begin
          rd_data = addr_q[`HM_WORD_BITS-1:0];
        end
        HM_CSR_ADDR_HI: begin
          rd_data = addr_q[`HM_DWORD_BITS-1:`HM_WORD_BITS];
        end
        HM_CSR_STATE: begin
          rd_data[1:0] = seq_state_i;
        end
        default: begin
          rd_data = '0;
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      csr_do_o   <= '0;
      irq_en_q   <= 1'b0;
      start_q    <= 1'b0;
      ev_end_q   <= 1'b0;
      ev_tx_to_q <= 1'b0;
      ev_rx_to_q <= 1'b0;
      addr_q     <= '0;
    end else begin
      csr_do_o <= rd_data;
      // Start is a single-cycle pulse
      start_q  <= 1'b0;
      if (bank_sel && csr_we_i) begin
        case (reg_ofs)
          HM_CSR_STAT: begin
            // Write one to clear, only between transactions
            if (seq_idle) begin
              if (csr_di_i[0]) begin
                ev_end_q <= 1'b0;
              end
              if (csr_di_i[1]) begin
                ev_tx_to_q <= 1'b0;
              end
              if (csr_di_i[2]) begin
                ev_rx_to_q <= 1'b0;
              end
            end
          end
          HM_CSR_CTRL: begin
            if (seq_idle) begin
              irq_en_q <= csr_di_i[0];
            end
            start_q <= csr_di_i[1];
          end
          HM_CSR_ADDR_LO: begin
            addr_q[`HM_WORD_BITS-1:0] <= csr_di_i;
          end
          HM_CSR_ADDR_HI: begin
            addr_q[`HM_DWORD_BITS-1:`HM_WORD_BITS] <= csr_di_i;
          end
          default: begin
          end
        endcase
      end
      // Event pulses take priority over a clear
      if (seq_end_i) begin
        ev_end_q <= 1'b1;
      end
      if (seq_tx_timeout_i) begin
        ev_tx_to_q <= 1'b1;
      end
      if (seq_rx_timeout_i) begin
        ev_rx_to_q <= 1'b1;
      end
    end
  end

  assign seq_start_o = start_q;

  // Page-aligned host address for the transport
  assign tx_addr_o = {addr_q[`HM_DWORD_BITS-1:`HM_PAGE_BITS], {`HM_PAGE_BITS{1'b0}}};

  assign irq_o = irq_en_q & (ev_end_q | ev_tx_to_q | ev_rx_to_q);

endmodule

// ==== hm_seq_pkg.sv ====
package hm_seq_pkg;

  // Transaction sequencer states
  typedef enum logic [1:0] {
    HM_IDLE = 2'd0,
    HM_SEND = 2'd1,
    HM_RECV = 2'd2
  } hm_state_e;

endpackage

// ==== hm_sequencer.sv ====
`timescale 1ns/1ps
`include "hm_settings.svh"

module hm_sequencer (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  logic                  start_i,
  input  logic                  tx_done_i,
  input  logic                  rx_done_i,
  output hm_seq_pkg::hm_state_e state_o,
  output logic                  tx_start_o,
  output logic                  end_o,
  output logic                  tx_timeout_o,
  output logic                  rx_timeout_o
);
  import hm_seq_pkg::*;

  hm_state_e                   state_q;
  logic [`HM_TIMEOUT_BITS-1:0] wdog_q;
  logic                        wdog_expired;
  logic                        tx_start_q;
  logic                        end_q;
  logic                        tx_to_q;
  logic                        rx_to_q;

  // Last count before the watchdog wraps
  assign wdog_expired = &wdog_q;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state_q    <= HM_IDLE;
      wdog_q     <= '0;
      tx_start_q <= 1'b0;
      end_q      <= 1'b0;
      tx_to_q    <= 1'b0;
      rx_to_q    <= 1'b0;
    end else begin
      tx_start_q <= 1'b0;
      end_q      <= 1'b0;
      tx_to_q    <= 1'b0;
      rx_to_q    <= 1'b0;

      // Runs across SEND and RECV without restarting
      if (state_q == HM_IDLE) begin
        wdog_q <= '0;
      end else begin
        wdog_q <= wdog_q + 1'b1;
      end

      case (state_q)
        HM_IDLE: begin
          if (start_i) begin
            state_q    <= HM_SEND;
            tx_start_q <= 1'b1;
          end
        end
        HM_SEND: begin
          if (wdog_expired) begin
            state_q <= HM_IDLE;
            tx_to_q <= 1'b1;
          end else if (tx_done_i) begin
            state_q <= HM_RECV;
          end
        end
        HM_RECV: begin
          if (wdog_expired) begin
            state_q <= HM_IDLE;
            rx_to_q <= 1'b1;
          end else if (rx_done_i) begin
            state_q <= HM_IDLE;
            end_q   <= 1'b1;
          end
        end
        default: begin
          state_q <= HM_IDLE;
          wdog_q  <= '0;
        end
      endcase
    end
  end

  assign state_o      = state_q;
  assign tx_start_o   = tx_start_q;
  assign end_o        = end_q;
  assign tx_timeout_o = tx_to_q;
  assign rx_timeout_o = rx_to_q;

endmodule

// ==== hm_settings.svh ====
`ifndef HM_SETTINGS_SVH
`define HM_SETTINGS_SVH

// CSR bank matched against csr_a_i[13:10]
`define HM_CSR_BANK 4'h0

// Register offset width inside the bank
`define HM_CSR_OFS_BITS 10

// Bus and buffer word widths
`define HM_WORD_BITS 32
`define HM_DWORD_BITS 64

// Buffer index width, 512 entries of 64 bits
`define HM_BUF_ADDR_BITS 9

// Watchdog counter width
`define HM_TIMEOUT_BITS 16

// Low address bits cleared in the transport address
`define HM_PAGE_BITS 12

`endif

// ==== hm_tests.txt ====
# W/R: csr field (xored onto bank base), data or expected. B: wb address, data or r, select
# Q: wb address, expected or r. H: host address, expected 64-bit. S: tx delay, rx delay. T: phase
R 0 0
R 1 0
R 2 0
R 3 0
R 4 0
W 2 89abc123
W 3 01234567
R 2 89abc123
R 3 01234567
R 402 0
R 1002 0
B 0 11223344 f
B 4 aabbccdd f
Q 0 11223344
Q 4 aabbccdd
H 0 ddccbbaa44332211
B 0 0000ee00 2
Q 0 1122ee44
H 0 ddccbbaa44ee2211
Q 1004 aabbccdd
B 8 r f
B ff8 cafef00d f
B ffc 01020304 f
Q 8 r
H ff8 040302010df0feca
S 3 5
S 0 0
R 1 1
T 1
T 2
W 0 7
R 0 0
R 4 0

// ==== hm_top.sv ====
`timescale 1ns/1ps

module hm_top (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  // CSR bus
  input  logic [13:0]           csr_a_i,
  input  logic                  csr_we_i,
  input  hm_csr_pkg::hm_word_t  csr_di_i,
  output hm_csr_pkg::hm_word_t  csr_do_o,
  // Wishbone bus
  input  logic [31:0]           wb_adr_i,
  input  hm_csr_pkg::hm_word_t  wb_dat_i,
  input  logic [3:0]            wb_sel_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_we_i,
  output hm_csr_pkg::hm_word_t  wb_dat_o,
  output logic                  wb_ack_o,
  // Host read port
  input  hm_csr_pkg::hm_dword_t hm_addr_i,
  output hm_csr_pkg::hm_dword_t hm_data_o,
  // Transport
  input  logic                  tx_done_i,
  input  logic                  rx_done_i,
  output logic                  tx_start_o,
  output hm_csr_pkg::hm_dword_t tx_addr_o,
  output logic                  irq_o
);
  import hm_seq_pkg::*;

  logic      seq_start;
  logic      seq_end;
  logic      seq_tx_timeout;
  logic      seq_rx_timeout;
  hm_state_e seq_state;

  hm_csr_regs u_csr_regs (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .csr_a_i         (csr_a_i),
    .csr_we_i        (csr_we_i),
    .csr_di_i        (csr_di_i),
    .csr_do_o        (csr_do_o),
    .seq_state_i     (seq_state),
    .seq_end_i       (seq_end),
    .seq_tx_timeout_i(seq_tx_timeout),
    .seq_rx_timeout_i(seq_rx_timeout),
    .seq_start_o     (seq_start),
    .tx_addr_o       (tx_addr_o),
    .irq_o           (irq_o)
  );

  hm_sequencer u_sequencer (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .start_i     (seq_start),
    .tx_done_i   (tx_done_i),
    .rx_done_i   (rx_done_i),
    .state_o     (seq_state),
    .tx_start_o  (tx_start_o),
    .end_o       (seq_end),
    .tx_timeout_o(seq_tx_timeout),
    .rx_timeout_o(seq_rx_timeout)
  );

  hm_buffer u_buffer (
    .sys_clk  (sys_clk),
    .sys_rst  (sys_rst),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .hm_addr_i(hm_addr_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .hm_data_o(hm_data_o)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mailbox testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_hm_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// ==== tb_hm_top.sv ====
`timescale 1ns/1ps
`include "hm_settings.svh"

module tb_hm_top;
  import hm_csr_pkg::*;
  import hm_seq_pkg::*;

  logic        sys_clk;
  logic        sys_rst;
  logic [13:0] csr_a;
  logic        csr_we;
  hm_word_t    csr_di;
  hm_word_t    csr_do;
  logic [31:0] wb_adr;
  hm_word_t    wb_dat_w;
  logic [3:0]  wb_sel;
  logic        wb_stb;
  logic        wb_cyc;
  logic        wb_we;
  hm_word_t    wb_dat_r;
  logic        wb_ack;
  hm_dword_t   hm_addr;
  hm_dword_t   hm_data;
  logic        tx_done;
  logic        rx_done;
  logic        tx_start;
  hm_dword_t   tx_addr;
  logic        irq;

  int          errors;
  int          checks;
  int          num_ops;
  int          cyc_cnt;
  string       lines[$];
  hm_word_t    rand_mem [0:1023];
  logic [2:0]  stat_m;
  logic        irq_en_m;
  hm_dword_t   addr_m;

  hm_top DUT (
    .sys_clk(sys_clk), .sys_rst(sys_rst),
    .csr_a_i(csr_a), .csr_we_i(csr_we), .csr_di_i(csr_di), .csr_do_o(csr_do),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_stb_i(wb_stb),
    .wb_cyc_i(wb_cyc), .wb_we_i(wb_we), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
    .hm_addr_i(hm_addr), .hm_data_o(hm_data),
    .tx_done_i(tx_done), .rx_done_i(rx_done), .tx_start_o(tx_start),
    .tx_addr_o(tx_addr), .irq_o(irq)
  );

  always #10 sys_clk = ~sys_clk;

  always @(posedge sys_clk) cyc_cnt <= cyc_cnt + 1;

  task automatic check_word(input string what, input hm_word_t got, input hm_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_dword(input string what, input hm_dword_t got, input hm_dword_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_state(input hm_state_e got, input hm_state_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: state is %s, expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Field is xored onto the bank base so upper bits select another bank
  function automatic logic [13:0] csr_addr(input logic [13:0] field);
    return {4'(`HM_CSR_BANK), 10'h0} ^ field;
  endfunction

  task automatic csr_write(input logic [13:0] field, input hm_word_t data);
    @(posedge sys_clk);
    csr_a  <= csr_addr(field);
    csr_di <= data;
    csr_we <= 1'b1;
    @(posedge sys_clk);
    csr_we <= 1'b0;
  endtask

  task automatic csr_read(input logic [13:0] field, output hm_word_t data);
    @(posedge sys_clk);
    csr_a <= csr_addr(field);
    @(posedge sys_clk);
    @(negedge sys_clk);
    data = csr_do;
  endtask

  task automatic wb_access(input logic we, input logic [31:0] adr, input hm_word_t data,
                           input logic [3:0] sel, output hm_word_t rdata);
    int n;
    n = 0;
    @(posedge sys_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    wb_sel   <= sel;
    do begin
      @(negedge sys_clk);
      n++;
    end while (!wb_ack && n < 4);
    if (!wb_ack) begin
      errors++;
      $display("Wishbone access to address %h was never acknowledged", adr);
    end
    rdata = wb_dat_r;
    @(posedge sys_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge sys_clk);
    check_bit("wb_ack_o after the access", wb_ack, 1'b0);
  endtask

  task automatic pulse(input logic is_rx);
    @(posedge sys_clk);
    if (is_rx) rx_done <= 1'b1;
    else tx_done <= 1'b1;
    @(posedge sys_clk);
    rx_done <= 1'b0;
    tx_done <= 1'b0;
  endtask

  task automatic run_transaction(input int txd, input int rxd);
    hm_word_t rd;
    csr_write(14'd1, 32'h3);
    irq_en_m = 1'b1;
    @(negedge sys_clk);
    check_bit("tx_start_o one cycle after start", tx_start, 1'b0);
    @(negedge sys_clk);
    check_bit("tx_start_o two cycles after start", tx_start, 1'b1);
    check_dword("tx_addr_o", tx_addr, {addr_m[63:12], 12'h0});
    @(negedge sys_clk);
    check_bit("tx_start_o after its pulse", tx_start, 1'b0);
    csr_read(14'd4, rd);
    check_state(hm_state_e'(rd[1:0]), HM_SEND);
    repeat (txd) @(posedge sys_clk);
    pulse(1'b0);
    csr_read(14'd4, rd);
    check_state(hm_state_e'(rd[1:0]), HM_RECV);
    repeat (rxd) @(posedge sys_clk);
    pulse(1'b1);
    csr_read(14'd4, rd);
    check_state(hm_state_e'(rd[1:0]), HM_IDLE);
    stat_m[0] = 1'b1;
    csr_read(14'd0, rd);
    check_word("STAT after transaction", rd, {29'h0, stat_m});
    check_bit("irq_o after transaction", irq, 1'b1);
    csr_write(14'd0, 32'h1);
    stat_m[0] = 1'b0;
    @(negedge sys_clk);
    check_bit("irq_o after clear", irq, irq_en_m && stat_m != 0);
    csr_read(14'd0, rd);
    check_word("STAT after clear", rd, {29'h0, stat_m});
  endtask

  task automatic run_timeout(input int phase);
    hm_word_t rd;
    int       c1;
    int       n;
    int       limit;
    limit = (1 << `HM_TIMEOUT_BITS);
    csr_write(14'd1, 32'h3);
    irq_en_m = 1'b1;
    @(negedge sys_clk);
    c1 = cyc_cnt;
    // Clear attempt while busy must be ignored
    csr_write(14'd0, 32'h7);
    if (phase == 2) pulse(1'b0);
    @(posedge sys_clk);
    csr_a <= csr_addr(14'd4);
    @(posedge sys_clk);
    n = 0;
    do begin
      @(negedge sys_clk);
      n++;
    end while (csr_do[1:0] != 2'd0 && n < limit + 16);
    if (csr_do[1:0] != 2'd0) begin
      errors++;
      $display("Watchdog never returned the sequencer to IDLE");
    end
    // One edge into SEND plus one edge of STATE read delay
    checks++;
    if (cyc_cnt - c1 != limit + 2) begin
      errors++;
      $display("Error at %0d ns: timeout took %0d cycles, expected %0d", $time,
               cyc_cnt - c1, limit + 2);
    end
    stat_m = stat_m | (phase == 2 ? 3'b100 : 3'b010);
    csr_read(14'd0, rd);
    check_word("STAT after timeout", rd, {29'h0, stat_m});
    check_bit("irq_o after timeout", irq, irq_en_m && stat_m != 0);
  endtask

  initial begin
    int fd;
    string line, op, tok;
    logic [31:0] f1, f2, f3;
    hm_dword_t e64;
    hm_word_t rd;
    hm_word_t exp;
    void'($urandom(32'hfbde));
    sys_clk  = 0;
    sys_rst  = 1;
    csr_a    = '0;
    csr_we   = 0;
    csr_di   = '0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    wb_stb   = 0;
    wb_cyc   = 0;
    wb_we    = 0;
    hm_addr  = '0;
    tx_done  = 0;
    rx_done  = 0;
    errors   = 0;
    checks   = 0;
    num_ops  = 0;
    cyc_cnt  = 0;
    stat_m   = '0;
    irq_en_m = 0;
    addr_m   = '0;
    fd = $fopen("hm_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file hm_tests.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0 && line.getc(0) != 8'h23 && $sscanf(line, "%s", op) == 1) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      num_ops = lines.size();
      repeat (5) @(posedge sys_clk);
      sys_rst <= 1'b0;
      foreach (lines[i]) begin
        void'($sscanf(lines[i], "%s", op));
        repeat ($urandom % 3) @(posedge sys_clk);
        case (op)
          "W": begin
            void'($sscanf(lines[i], "%s %h %h", op, f1, f2));
            csr_write(f1[13:0], f2);
            if (f1[13:10] == 4'h0) begin
              if (f1[9:0] == 10'd0) stat_m = stat_m & ~f2[2:0];
              if (f1[9:0] == 10'd1) irq_en_m = f2[0];
              if (f1[9:0] == 10'd2) addr_m[31:0] = f2;
              if (f1[9:0] == 10'd3) addr_m[63:32] = f2;
            end
          end
          "R": begin
            void'($sscanf(lines[i], "%s %h %h", op, f1, f2));
            csr_read(f1[13:0], rd);
            check_word($sformatf("CSR %h", f1[13:0]), rd, f2);
            if (f1[13:0] == 14'd4) check_state(hm_state_e'(rd[1:0]), hm_state_e'(f2[1:0]));
          end
          "B", "Q": begin
            void'($sscanf(lines[i], "%s %h %s %h", op, f1, tok, f3));
            if (tok == "r") begin
              exp = (op == "B") ? hm_word_t'($urandom) : rand_mem[f1[11:2]];
            end else begin
              void'($sscanf(tok, "%h", exp));
            end
            if (op == "B") begin
              rand_mem[f1[11:2]] = exp;
              wb_access(1'b1, f1, exp, f3[3:0], rd);
            end else begin
              wb_access(1'b0, f1, '0, 4'h0, rd);
              check_word($sformatf("Wishbone address %h", f1), rd, exp);
            end
          end
          "H": begin
            void'($sscanf(lines[i], "%s %h %h", op, f1, e64));
            @(posedge sys_clk);
            hm_addr <= {32'h0, f1};
            @(posedge sys_clk);
            @(negedge sys_clk);
            check_dword($sformatf("host address %h", f1), hm_data, e64);
          end
          "S": begin
            void'($sscanf(lines[i], "%s %h %h", op, f1, f2));
            run_transaction(f1, f2);
          end
          "T": begin
            void'($sscanf(lines[i], "%s %h", op, f1));
            run_timeout(f1);
          end
          default: begin
            errors++;
            $display("Unknown operation in test file line: %s", lines[i]);
          end
        endcase
      end
      $display("Operations: %0d, checks: %0d, errors: %0d", num_ops, checks, errors);
      if (errors == 0 && checks > 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

  initial begin
    wait (num_ops > 0);
    repeat (num_ops * 70000) @(posedge sys_clk);
    $display("The run timed out before all operations finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule
